//--- common/aesFieldPkg.sv
package aesFieldPkg;

  localparam int numRounds = 10;
  localparam int numKeys = numRounds + 1;

  // low byte of x^8 + x^4 + x^3 + x + 1
  localparam logic [7:0] gfPoly = 8'h1b;

  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? gfPoly : 8'h00);
  endfunction

  // shift-and-add multiply in GF(2^8)
  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] prod;
    logic [7:0] term;
    prod = 8'h00;
    term = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        prod = prod ^ term;
      end
      term = xtime(term);
    end
    return prod;
  endfunction

  // a^254 is the inverse for a != 0, and 0 maps to 0
  function automatic logic [7:0] gfInv(input logic [7:0] a);
    logic [7:0] p2;
    logic [7:0] p4;
    logic [7:0] p8;
    logic [7:0] p16;
    logic [7:0] p32;
    logic [7:0] p64;
    logic [7:0] p128;
    logic [7:0] acc;
    p2 = gfMul(a, a);
    p4 = gfMul(p2, p2);
    p8 = gfMul(p4, p4);
    p16 = gfMul(p8, p8);
    p32 = gfMul(p16, p16);
    p64 = gfMul(p32, p32);
    p128 = gfMul(p64, p64);
    acc = gfMul(p128, p64);
    acc = gfMul(acc, p32);
    acc = gfMul(acc, p16);
    acc = gfMul(acc, p8);
    acc = gfMul(acc, p4);
    acc = gfMul(acc, p2);
    return acc;
  endfunction

  // undo the affine map first, then invert in the field
  function automatic logic [7:0] invSbox(input logic [7:0] a);
    logic [7:0] lin;
    lin = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
    return gfInv(lin);
  endfunction

endpackage

//--- common/aesBlockPkg.sv
package aesBlockPkg;

  typedef logic [7:0] aesByte;

  // one state column with row 0 in the top byte
  typedef logic [31:0] aesWord;

  // byte index is 4 * column + row; column 0 sits in the top word
  typedef union packed {
    aesByte [0:15] bytes;
    aesWord [0:3] cols;
  } aesState;

  // round key index from 0 to 10
  typedef logic [3:0] roundIdx;

endpackage

//--- common/roundStateIf.sv
`timescale 1ns/1ps

interface roundStateIf
  import aesBlockPkg::*;
();

  aesState stateIn;
  aesState roundKey;
  logic lastRound;
  aesState stateOut;

  modport ctrl (
    output stateIn,
    output lastRound,
    input stateOut
  );

  modport unit (
    input stateIn,
    input roundKey,
    input lastRound,
    output stateOut
  );

endinterface

//--- hw/invMixColumn.sv
`timescale 1ns/1ps

module invMixColumn
  import aesFieldPkg::*;
  import aesBlockPkg::*;
(
  input aesWord col,
  output aesWord mixed
);

  aesByte b0;
  aesByte b1;
  aesByte b2;
  aesByte b3;

  assign b0 = col[31:24];
  assign b1 = col[23:16];
  assign b2 = col[15:8];
  assign b3 = col[7:0];

  // coefficients 0e 0b 0d 09 rotate right by one per row
  assign mixed[31:24] = gfMul(b0, 8'h0e) ^ gfMul(b1, 8'h0b)
                      ^ gfMul(b2, 8'h0d) ^ gfMul(b3, 8'h09);
  assign mixed[23:16] = gfMul(b0, 8'h09) ^ gfMul(b1, 8'h0e)
                      ^ gfMul(b2, 8'h0b) ^ gfMul(b3, 8'h0d);
  assign mixed[15:8]  = gfMul(b0, 8'h0d) ^ gfMul(b1, 8'h09)
                      ^ gfMul(b2, 8'h0e) ^ gfMul(b3, 8'h0b);
  assign mixed[7:0]   = gfMul(b0, 8'h0b) ^ gfMul(b1, 8'h0d)
                      ^ gfMul(b2, 8'h09) ^ gfMul(b3, 8'h0e);

endmodule

//--- invCipher/invRoundUnit.sv
`timescale 1ns/1ps

module invRoundUnit
  import aesFieldPkg::*;
  import aesBlockPkg::*;
(
  roundStateIf.unit rs
);

  aesState shifted;
  aesState subbed;
  aesState keyed;
  aesState mixedState;

  // row r moves right by r columns
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[4 * c + r] = rs.stateIn.bytes[4 * ((c - r + 4) % 4) + r];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 16; i++) begin
      subbed.bytes[i] = invSbox(shifted.bytes[i]);
    end
  end

  assign keyed = subbed ^ rs.roundKey;

  for (genvar c = 0; c < 4; c++) begin : genMix
    invMixColumn mixCol (
      .col(keyed.cols[c]),
      .mixed(mixedState.cols[c])
    );
  end

  // final round has no InvMixColumns
  assign rs.stateOut = rs.lastRound ? keyed : mixedState;

endmodule

//--- invCipher/invCipherCtrl.sv
`timescale 1ns/1ps

module invCipherCtrl
  import aesFieldPkg::*;
  import aesBlockPkg::*;
(
  input logic clk,
  input logic reset,
  input logic inValid,
  output logic inReady,
  input aesState cipherText,
  output logic outValid,
  input logic outReady,
  output aesState plainText,
  output roundIdx keyIdx,
  input aesState initKey,
  roundStateIf.ctrl rs
);

  aesState stateReg;
  roundIdx roundCnt;
  logic busy;
  logic done;
  logic accept;

  // counter parks at 10 while idle, so the initial key is already selected
  assign busy = (roundCnt != roundIdx'(numRounds));
  assign keyIdx = roundCnt;

  assign inReady = !busy && !done;
  assign accept = inValid && inReady;
  assign outValid = done;
  assign plainText = stateReg;

  assign rs.stateIn = stateReg;
  assign rs.lastRound = (roundCnt == roundIdx'(0));

  always_ff @(posedge clk) begin
    if (reset) begin
      roundCnt <= roundIdx'(numRounds);
      done <= 1'b0;
    end else begin
      if (accept) begin
        roundCnt <= roundIdx'(numRounds - 1);
      end else if (busy) begin
        if (roundCnt == roundIdx'(0)) begin
          roundCnt <= roundIdx'(numRounds);
          done <= 1'b1;
        end else begin
          roundCnt <= roundCnt - roundIdx'(1);
        end
      end
      if (done && outReady) begin
        done <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stateReg <= cipherText ^ initKey;
    end else if (busy) begin
      stateReg <= rs.stateOut;
    end
  end

  // result must hold while the sink stalls
  assert property (@(posedge clk) disable iff (reset)
    outValid && !outReady |=> outValid && $stable(plainText));

  // counter stays parked while a result is offered
  assert property (@(posedge clk) disable iff (reset)
    outValid |-> !busy);

endmodule

//--- invCipher/roundKeyStore.sv
`timescale 1ns/1ps

module roundKeyStore
  import aesFieldPkg::*;
  import aesBlockPkg::*;
(
  input logic clk,
  input logic reset,
  input logic keyWrite,
  input roundIdx keyIdxIn,
  input aesState keyData,
  input roundIdx keyIdx,
  output aesState roundKey
);

  aesState keyReg [numKeys];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < numKeys; i++) begin
        keyReg[i] <= '0;
      end
    end else if (keyWrite) begin
      keyReg[keyIdxIn] <= keyData;
    end
  end

  // controller only ever asks for 0 to 10
  assign roundKey = keyReg[keyIdx];

  assert property (@(posedge clk) disable iff (reset)
    keyWrite |-> keyIdxIn <= roundIdx'(numKeys - 1));

endmodule

//--- hw/aesDecryptTop.sv
`timescale 1ns/1ps

module aesDecryptTop
  import aesBlockPkg::*;
(
  input logic clk,
  input logic reset,
  input logic keyWrite,
  input roundIdx keyIdxIn,
  input aesState keyData,
  input logic inValid,
  output logic inReady,
  input aesState cipherText,
  output logic outValid,
  input logic outReady,
  output aesState plainText
);

  roundIdx keyIdx;
  aesState roundKey;

  roundStateIf rs ();

  // one key read serves both the initial XOR and the round unit
  assign rs.roundKey = roundKey;

  roundKeyStore keyStore (
    .clk(clk),
    .reset(reset),
    .keyWrite(keyWrite),
    .keyIdxIn(keyIdxIn),
    .keyData(keyData),
    .keyIdx(keyIdx),
    .roundKey(roundKey)
  );

  invCipherCtrl cipherCtrl (
    .clk(clk),
    .reset(reset),
    .inValid(inValid),
    .inReady(inReady),
    .cipherText(cipherText),
    .outValid(outValid),
    .outReady(outReady),
    .plainText(plainText),
    .keyIdx(keyIdx),
    .initKey(roundKey),
    .rs(rs.ctrl)
  );

  invRoundUnit roundUnit (
    .rs(rs.unit)
  );

endmodule

//--- verif/aesRefModel.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// filled once by buildRefTables, before any key is expanded
logic [7:0] refSbox [256];
logic [7:0] refInvSbox [256];
logic [127:0] refKeys [11];

function automatic logic [7:0] refMul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] x;
  logic [7:0] y;
  logic [7:0] p;
  x = a;
  y = b;
  p = 8'h00;
  while (y != 8'h00) begin
    if (y[0]) begin
      p = p ^ x;
    end
    x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    y = y >> 1;
  end
  return p;
endfunction

// forward S-box from a brute-force inverse, then invert the table
task automatic buildRefTables();
  logic [7:0] inv;
  logic [7:0] s;
  for (int x = 0; x < 256; x++) begin
    inv = 8'h00;
    for (int y = 1; y < 256; y++) begin
      if (refMul(8'(x), 8'(y)) == 8'h01) begin
        inv = 8'(y);
      end
    end
    s = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
        ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    refSbox[x] = s;
    refInvSbox[s] = 8'(x);
  end
endtask

task automatic expandKey(input logic [127:0] key);
  logic [31:0] w [44];
  logic [31:0] t;
  logic [7:0] rcon;
  rcon = 8'h01;
  for (int i = 0; i < 4; i++) begin
    w[i] = key[127 - 32 * i -: 32];
  end
  for (int i = 4; i < 44; i++) begin
    t = w[i - 1];
    if (i % 4 == 0) begin
      t = {refSbox[t[23:16]], refSbox[t[15:8]], refSbox[t[7:0]], refSbox[t[31:24]]}
          ^ {rcon, 24'h000000};
      rcon = refMul(rcon, 8'h02);
    end
    w[i] = w[i - 4] ^ t;
  end
  for (int k = 0; k < 11; k++) begin
    refKeys[k] = {w[4 * k], w[4 * k + 1], w[4 * k + 2], w[4 * k + 3]};
  end
endtask

function automatic logic [127:0] refDecrypt(input logic [127:0] ct);
  logic [7:0] s [16];
  logic [7:0] t [16];
  logic [7:0] coef [4];
  logic [127:0] blk;
  coef[0] = 8'h0e;
  coef[1] = 8'h0b;
  coef[2] = 8'h0d;
  coef[3] = 8'h09;
  blk = ct ^ refKeys[10];
  for (int rnd = 9; rnd >= 0; rnd--) begin
    for (int i = 0; i < 16; i++) begin
      s[i] = blk[127 - 8 * i -: 8];
    end
    // byte in row r, column c moves to column c + r
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        t[4 * ((c + r) % 4) + r] = refInvSbox[s[4 * c + r]];
      end
    end
    for (int i = 0; i < 16; i++) begin
      t[i] = t[i] ^ refKeys[rnd][127 - 8 * i -: 8];
      s[i] = t[i];
    end
    if (rnd > 0) begin
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          s[4 * c + r] = 8'h00;
          for (int j = 0; j < 4; j++) begin
            s[4 * c + r] = s[4 * c + r] ^ refMul(t[4 * c + j], coef[(j - r + 4) % 4]);
          end
        end
      end
    end
    for (int i = 0; i < 16; i++) begin
      blk[127 - 8 * i -: 8] = s[i];
    end
  end
  return blk;
endfunction

`endif

//--- verif/aesDecryptTb.sv
`timescale 1ns/1ps

module aesDecryptTb
  import aesBlockPkg::*;
();

  localparam int clkPeriod = 20;
  localparam int blockCount = 26;
  localparam int cyclesPerBlock = 40;
  localparam int marginCycles = 200;
  localparam int expLatency = 11;

  logic clk = 1'b0;
  logic reset;
  logic keyWrite;
  roundIdx keyIdxIn;
  aesState keyData;
  logic inValid;
  logic inReady;
  aesState cipherText;
  logic outValid;
  logic outReady;
  aesState plainText;

  aesState expQ [$];
  string nameQ [$];
  logic [31:0] lcgState = 32'd18731;
  int checkedCount = 0;

  `include "aesRefModel.svh"

  aesDecryptTop u_dut (
    .clk(clk),
    .reset(reset),
    .keyWrite(keyWrite),
    .keyIdxIn(keyIdxIn),
    .keyData(keyData),
    .inValid(inValid),
    .inReady(inReady),
    .cipherText(cipherText),
    .outValid(outValid),
    .outReady(outReady),
    .plainText(plainText)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "%s", reason);
  endtask

  task automatic checkState(input string name, input aesState exp, input aesState got);
    if (got !== exp) begin
      failRun($sformatf("ERR %s exp %h got %h", name, exp, got));
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      failRun($sformatf("ERR %s exp %b got %b", name, exp, got));
    end
  endtask

  task automatic checkLatency(input string name, input int exp, input int got);
    if (got != exp) begin
      failRun($sformatf("ERR %s exp %0d got %0d", name, exp, got));
    end
  endtask

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic aesState randState();
    aesState v;
    for (int i = 0; i < 4; i++) begin
      v.cols[i] = nextRand();
    end
    return v;
  endfunction

  // host side key expansion, then one write per round key
  task automatic loadKeys(input logic [127:0] key);
    expandKey(key);
    for (int k = 0; k < 11; k++) begin
      keyWrite = 1'b1;
      keyIdxIn = roundIdx'(k);
      keyData = refKeys[k];
      @(posedge clk);
      #1;
    end
    keyWrite = 1'b0;
  endtask

  task automatic runBlock(input string name, input aesState ct, input aesState exp,
                          input int stall);
    expQ.push_back(exp);
    nameQ.push_back(name);
    inValid = 1'b1;
    cipherText = ct;
    @(posedge clk);
    while (!inReady) begin
      @(posedge clk);
    end
    #1;
    inValid = 1'b0;
    @(posedge clk);
    while (!outValid) begin
      @(posedge clk);
    end
    // sink stalls before taking the result
    repeat (stall) @(posedge clk);
    #1;
    outReady = 1'b1;
    @(posedge clk);
    #1;
    outReady = 1'b0;
  endtask

  initial begin : monitor
    int cycleNum;
    int acceptCycle;
    logic inFlight;
    logic holdPending;
    logic prevOutValid;
    aesState heldText;
    aesState expText;
    string expName;
    cycleNum = 0;
    acceptCycle = 0;
    inFlight = 1'b0;
    holdPending = 1'b0;
    prevOutValid = 1'b0;
    forever begin
      @(posedge clk);
      cycleNum++;
      if (!reset) begin
        if (holdPending) begin
          checkBit("holdValid", 1'b1, outValid);
          checkState("holdText", heldText, plainText);
        end
        if (inFlight) begin
          checkBit("busyInReady", 1'b0, inReady);
        end
        if (outValid && !prevOutValid) begin
          if (!inFlight) begin
            failRun("outValid rose with no block in flight");
          end
          checkLatency("latency", expLatency, cycleNum - acceptCycle);
        end
        if (outValid && outReady) begin
          if (expQ.size() == 0) begin
            failRun("output transfer with no expected result");
          end
          expText = expQ.pop_front();
          expName = nameQ.pop_front();
          checkState(expName, expText, plainText);
          checkedCount++;
          inFlight = 1'b0;
        end
        holdPending = outValid && !outReady;
        heldText = plainText;
        if (inValid && inReady) begin
          inFlight = 1'b1;
          acceptCycle = cycleNum;
        end
        prevOutValid = outValid;
      end
    end
  end

  initial begin : watchdog
    #(clkPeriod * (blockCount * cyclesPerBlock + marginCycles));
    failRun("timeout waiting for output");
  end

  initial begin : testSeq
    aesState ct;
    aesState pt;
    logic [127:0] key;
    logic [31:0] r;
    int stall;
    reset = 1'b1;
    keyWrite = 1'b0;
    keyIdxIn = '0;
    keyData = '0;
    inValid = 1'b0;
    cipherText = '0;
    outReady = 1'b0;
    buildRefTables();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    checkBit("resetOutValid", 1'b0, outValid);
    checkBit("resetInReady", 1'b1, inReady);

    // FIPS-197 appendix C.1
    key = 128'h000102030405060708090a0b0c0d0e0f;
    ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    pt = 128'h00112233445566778899aabbccddeeff;
    loadKeys(key);
    checkState("refModelC1", pt, aesState'(refDecrypt(ct)));
    runBlock("fipsC1", ct, pt, 0);

    key = randState();
    loadKeys(key);
    for (int n = 0; n < 20; n++) begin
      ct = randState();
      r = nextRand();
      stall = int'(r[31:28]);
      runBlock($sformatf("random%0d", n), ct, aesState'(refDecrypt(ct)), stall);
    end

    // fresh key set between blocks
    key = randState();
    loadKeys(key);
    for (int n = 0; n < 5; n++) begin
      ct = randState();
      r = nextRand();
      stall = int'(r[31:28]);
      runBlock($sformatf("newKey%0d", n), ct, aesState'(refDecrypt(ct)), stall);
    end

    @(posedge clk);
    #1;
    if (expQ.size() == 0 && checkedCount == blockCount) begin
      $display("** PASS **");
      $finish;
    end else begin
      failRun($sformatf("only %0d of %0d results were checked", checkedCount, blockCount));
    end
  end

endmodule

//--- sources.f
+incdir+verif
common/aesFieldPkg.sv
common/aesBlockPkg.sv
common/roundStateIf.sv
hw/invMixColumn.sv
invCipher/invRoundUnit.sv
invCipher/invCipherCtrl.sv
invCipher/roundKeyStore.sv
hw/aesDecryptTop.sv
verif/aesDecryptTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run into a log, then look for the pass line

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simExe=aesDecryptSim
logFile=sim.log

verilator --binary --timing --assert \
  --top-module aesDecryptTb \
  --Mdir "$buildDir" -o "$simExe" \
  -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$buildDir/$simExe" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qF '** PASS **' "$logFile"; then
  exit 0
else
  echo "pass line not found in $logFile"
  exit 1
fi
